//--- src.f
+incdir+common
common/eeprom_pkg.sv
i2c_engine/i2c_bit_engine.sv
rtl/eeprom_access_fsm.sv
rtl/eeprom_ctrl_top.sv
bench/eeprom_model.sv
bench/tb_eeprom_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# build and run the EEPROM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_eeprom_ctrl -Mdir obj_dir -f src.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vtb_eeprom_ctrl
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

//--- bench/tb_eeprom_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_macros.svh"

module tb_eeprom_ctrl import eeprom_pkg::*; ();

    localparam int ACK_LIMIT = 4000;

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    ee_addr_t    addr;
    ee_byte_t    wdata;
    logic        ack;
    logic        ack_err;
    ee_byte_t    rdata;
    logic        scl;
    logic        sda_oe;
    logic        sda_pull;
    logic        sda_line;
    logic        absent;
    logic        bad_sda_move;
    logic        ctrl_seen;
    logic [3:0]  ctrl_code;
    ee_byte_t    mem_ref [0:(1 << `EE_ADDR_W)-1];
    logic [31:0] rng;

    assign sda_line = !(sda_oe || sda_pull);   // pull-up where either side pulls low

    eeprom_ctrl_top uut (
        .CLK (CLK), .RESET (RESET), .wr (wr), .rd (rd), .addr (addr), .wdata (wdata),
        .ack (ack), .ack_err (ack_err), .rdata (rdata), .scl (scl), .sda_in (sda_line),
        .sda_oe (sda_oe)
    );

    eeprom_model u_model (
        .CLK (CLK), .RESET (RESET), .absent (absent), .scl (scl), .sda (sda_line),
        .sda_pull (sda_pull), .bad_sda_move (bad_sda_move), .ctrl_seen (ctrl_seen),
        .ctrl_code (ctrl_code)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_eq(input string test, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else
            stop_with_failure($sformatf("** Error [%s]: expected 0x%0h, actual 0x%0h",
                                        test, exp, act));
    endtask

    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET) !bad_sda_move)
        else stop_with_failure("SDA changed while SCL was high in the middle of a byte");

    a_ctrl_code: assert property (@(posedge CLK) disable iff (RESET)
        ctrl_seen |-> ctrl_code == `EE_DEV_CODE)
        else stop_with_failure($sformatf("** Error [control byte]: expected 0x%0h, actual 0x%0h",
                                         `EE_DEV_CODE, ctrl_code));

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_cycle();
        @(posedge CLK);
        #2;
    endtask

    // one host request with ack held for hold extra cycles before the drop
    task automatic transfer(input logic is_read, input ee_addr_t a, input ee_byte_t d,
                            input int hold, output ee_byte_t q, output logic err);
        int n;
        addr  = a;
        wdata = d;
        wr    = !is_read;
        rd    = is_read;
        n     = 0;
        while (!ack && n < ACK_LIMIT) begin
            next_cycle();
            n++;
        end
        if (!ack)
            stop_with_failure("timeout: the controller never raised ack");
        q   = rdata;
        err = ack_err;
        for (n = 0; n < hold; n++) begin
            next_cycle();
            check_eq("ack held while request stays", 1, 32'(ack));
        end
        wr = 1'b0;
        rd = 1'b0;
        n  = 0;
        while (ack && n < 2) begin
            next_cycle();
            n++;
        end
        check_eq("ack falls after request drops", 0, 32'(ack));
    endtask

    task automatic write_byte(input string test, input ee_addr_t a, input ee_byte_t d,
                              input logic exp_err, input int hold);
        ee_byte_t q;
        logic     err;
        transfer(1'b0, a, d, hold, q, err);
        check_eq({test, ": ack_err"}, 32'(exp_err), 32'(err));
        if (!exp_err)
            mem_ref[a] = d;
    endtask

    task automatic read_check(input string test, input ee_addr_t a);
        ee_byte_t q;
        logic     err;
        transfer(1'b1, a, 8'h00, 0, q, err);
        check_eq({test, ": ack_err"}, 0, 32'(err));
        check_eq({test, ": rdata"}, 32'(mem_ref[a]), 32'(q));
    endtask

    initial begin
        ee_byte_t q;
        logic     err;
        ee_addr_t a;
        int       i;
        RESET   = 1'b1;
        wr      = 1'b0;
        rd      = 1'b0;
        addr    = '0;
        wdata   = '0;
        absent  = 1'b0;
        rng     = 32'hf6b;
        for (i = 0; i < (1 << `EE_ADDR_W); i++)
            mem_ref[i] = 8'(i[7:0] * 8'd37) ^ {i[10:8], 5'b01101};   // power-up contents
        repeat (16) next_cycle();
        RESET = 1'b0;
        next_cycle();

        check_eq("reset: ack", 0, 32'(ack));
        check_eq("reset: sda_oe", 0, 32'(sda_oe));
        check_eq("reset: scl", 1, 32'(scl));
        write_byte("basic write", 11'h123, 8'h5a, 1'b0, 0);
        read_check("basic read", 11'h123);

        a = 11'h123;
        for (i = 0; i < 30; i++) begin
            rng = xorshift(rng);
            write_byte("random write", rng[10:0], rng[18:11], 1'b0, 0);
            if (rng[31])
                a = rng[10:0];   // read back what was just written
            else
                a = rng[29:19];
            read_check("random read", a);
        end

        // same word address in all eight blocks
        for (i = 0; i < 8; i++)
            write_byte("alias write", {i[2:0], 8'h5c}, 8'(8'h30 + i * 17), 1'b0, 0);
        for (i = 0; i < 8; i++)
            read_check("alias read", {i[2:0], 8'h5c});

        write_byte("absent setup", 11'h2a5, 8'h3c, 1'b0, 0);
        absent = 1'b1;
        write_byte("absent write", 11'h2a5, 8'hc3, 1'b1, 0);
        check_eq("absent: scl idle", 1, 32'(scl));
        check_eq("absent: sda released", 0, 32'(sda_oe));
        transfer(1'b1, 11'h2a5, 8'h00, 0, q, err);
        check_eq("absent read: ack_err", 1, 32'(err));
        absent = 1'b0;
        read_check("read after absent", 11'h2a5);

        write_byte("handshake write", 11'h7ff, 8'h96, 1'b0, 12);
        read_check("handshake read", 11'h7ff);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/eeprom_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_macros.svh"

module eeprom_model (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       absent,         // device never acknowledges
    input  logic       scl,
    input  logic       sda,            // resolved bus line
    output logic       sda_pull,
    output logic       bad_sda_move,
    output logic       ctrl_seen,
    output logic [3:0] ctrl_code
);

    typedef enum logic [2:0] {M_IDLE, M_CTRL, M_ADDR, M_WDATA, M_RD_PEND, M_WAIT} m_state_t;

    logic [`EE_DATA_W-1:0] mem [0:(1 << `EE_ADDR_W)-1];
    m_state_t              phase;
    logic [3:0]            bit_idx;   // slot the next SCL rise clocks
    logic [`EE_DATA_W-1:0] sh;
    logic [`EE_ADDR_W-1:0] ptr;
    logic                  reading;
    logic                  ack_pend;
    logic                  scl_q;
    logic                  sda_q;
    logic [`EE_DATA_W-1:0] rx;
    logic                  start_det;
    logic                  stop_det;

    assign rx        = {sh[`EE_DATA_W-2:0], sda};
    assign start_det = scl && scl_q && sda_q && !sda;
    assign stop_det  = scl && scl_q && !sda_q && sda;

    // SDA may only move with SCL high in the first bit slot, where START and STOP live
    assign bad_sda_move = scl && scl_q && (sda != sda_q) && (phase != M_IDLE) && (bit_idx != 4'd1);

    initial begin
        for (int a = 0; a < (1 << `EE_ADDR_W); a++)
            mem[a] = 8'(a[7:0] * 8'd37) ^ {a[10:8], 5'b01101};
    end

    always @(posedge CLK) begin
        scl_q     <= scl;
        sda_q     <= sda;
        ctrl_seen <= 1'b0;
        if (RESET) begin
            phase    <= M_IDLE;
            bit_idx  <= '0;
            sda_pull <= 1'b0;
            reading  <= 1'b0;
            ack_pend <= 1'b0;
            scl_q    <= 1'b1;
            sda_q    <= 1'b1;
        end else if (start_det || stop_det) begin
            phase    <= start_det ? M_CTRL : M_IDLE;
            bit_idx  <= '0;
            reading  <= 1'b0;
            sda_pull <= 1'b0;
        end else if (phase != M_IDLE && scl && !scl_q) begin
            if (bit_idx == 4'd8) begin
                bit_idx <= '0;
                reading <= (phase == M_RD_PEND);   // master ack slot ends a read
                if (phase == M_RD_PEND) begin
                    phase    <= M_WAIT;
                    ack_pend <= 1'b0;
                end
            end else begin
                bit_idx <= bit_idx + 4'd1;
                sh      <= rx;
                if (bit_idx == 4'd7 && !reading) begin
                    case (phase)
                        M_CTRL: begin
                            ctrl_seen  <= 1'b1;
                            ctrl_code  <= rx[7:4];
                            ack_pend   <= !absent && (rx[7:4] == `EE_DEV_CODE);
                            ptr[10:8]  <= rx[3:1];
                            phase      <= absent ? M_WAIT : (rx[0] ? M_RD_PEND : M_ADDR);
                        end
                        M_ADDR: begin
                            ptr[7:0] <= rx;
                            phase    <= M_WDATA;
                        end
                        M_WDATA: begin
                            mem[ptr] <= rx;
                            phase    <= M_WAIT;
                        end
                        default: ack_pend <= 1'b0;
                    endcase
                end
            end
        end else if (phase != M_IDLE && !scl && scl_q) begin
            if (bit_idx == 4'd8)
                sda_pull <= ack_pend;
            else
                sda_pull <= reading && !mem[ptr][3'd7 - bit_idx[2:0]];   // MSB first
        end
    end

endmodule

`default_nettype wire

//--- rtl/eeprom_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl_top import eeprom_pkg::*; (
    input  logic     CLK,
    input  logic     RESET,
    input  logic     wr,
    input  logic     rd,
    input  ee_addr_t addr,
    input  ee_byte_t wdata,
    output logic     ack,
    output logic     ack_err,
    output ee_byte_t rdata,
    output logic     scl,
    input  logic     sda_in,
    output logic     sda_oe
);

    logic     cmd_req;
    logic     cmd_ack;
    bit_cmd_t cmd;
    ee_byte_t cmd_tx_byte;
    logic     cmd_tx_nack;
    ee_byte_t rx_byte;
    logic     rx_nack;

    eeprom_access_fsm u_seq (
        .CLK         (CLK),
        .RESET       (RESET),
        .wr          (wr),
        .rd          (rd),
        .addr        (addr),
        .wdata       (wdata),
        .ack         (ack),
        .ack_err     (ack_err),
        .rdata       (rdata),
        .cmd_req     (cmd_req),
        .cmd         (cmd),
        .cmd_tx_byte (cmd_tx_byte),
        .cmd_tx_nack (cmd_tx_nack),
        .cmd_ack     (cmd_ack),
        .rx_byte     (rx_byte),
        .rx_nack     (rx_nack)
    );

    // bus pins come straight from the bit engine
    i2c_bit_engine u_eng (
        .CLK         (CLK),
        .RESET       (RESET),
        .cmd_req     (cmd_req),
        .cmd         (cmd),
        .cmd_tx_byte (cmd_tx_byte),
        .cmd_tx_nack (cmd_tx_nack),
        .cmd_ack     (cmd_ack),
        .rx_byte     (rx_byte),
        .rx_nack     (rx_nack),
        .scl         (scl),
        .sda_in      (sda_in),
        .sda_oe      (sda_oe)
    );

endmodule

`default_nettype wire

//--- rtl/eeprom_access_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_macros.svh"

module eeprom_access_fsm import eeprom_pkg::*; (
    input  logic     CLK,
    input  logic     RESET,
    input  logic     wr,
    input  logic     rd,
    input  ee_addr_t addr,
    input  ee_byte_t wdata,
    output logic     ack,
    output logic     ack_err,
    output ee_byte_t rdata,
    output logic     cmd_req,
    output bit_cmd_t cmd,
    output ee_byte_t cmd_tx_byte,
    output logic     cmd_tx_nack,
    input  logic     cmd_ack,
    input  ee_byte_t rx_byte,
    input  logic     rx_nack
);

    seq_state_t state;
    seq_state_t nxt;
    logic       is_rd;
    ee_addr_t   addr_q;
    ee_byte_t   wdata_q;
    logic       accept;
    logic       cmd_done;

    assign accept   = (state == IDLE) && (wr || rd);
    assign cmd_done = cmd_req && cmd_ack;

    // single byte read always ends with NACK
    assign cmd_tx_nack = (state == DATA_R);

    always_comb begin
        case (state)
            START_W: nxt = CTRL_W;
            CTRL_W:  nxt = ADDR_W;
            ADDR_W:  nxt = is_rd ? RESTART : DATA_W;
            DATA_W:  nxt = STOP;
            RESTART: nxt = CTRL_R;
            CTRL_R:  nxt = DATA_R;
            DATA_R:  nxt = STOP;
            STOP:    nxt = DONE;
            default: nxt = IDLE;
        endcase
    end

    // one engine command per state
    always_comb begin
        cmd         = CMD_WRITE;
        cmd_tx_byte = '0;
        case (state)
            START_W, RESTART: cmd = CMD_START;
            CTRL_W:  cmd_tx_byte = {`EE_DEV_CODE, addr_q[`EE_ADDR_W-1:8], 1'b0};
            ADDR_W:  cmd_tx_byte = addr_q[7:0];
            DATA_W:  cmd_tx_byte = wdata_q;
            CTRL_R:  cmd_tx_byte = {`EE_DEV_CODE, addr_q[`EE_ADDR_W-1:8], 1'b1};
            DATA_R:  cmd = CMD_READ;
            default: cmd = CMD_STOP;   // STOP, req is low elsewhere
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state   <= IDLE;
            cmd_req <= 1'b0;
            ack     <= 1'b0;
            ack_err <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        ack_err <= 1'b0;
                        state   <= START_W;
                    end
                end

                DONE: begin
                    // hold ack until the host lets go
                    if (!wr && !rd) begin
                        ack   <= 1'b0;
                        state <= IDLE;
                    end
                end

                default: begin
                    if (!cmd_req && !cmd_ack) begin
                        cmd_req <= 1'b1;   // previous handshake fully closed
                    end else if (cmd_done) begin
                        cmd_req <= 1'b0;
                        if (cmd == CMD_WRITE && rx_nack) begin
                            ack_err <= 1'b1;   // no device ack, wind down
                            state   <= STOP;
                        end else begin
                            state <= nxt;
                        end
                        if (state == STOP) ack <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            is_rd   <= rd;
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (state == DATA_R && cmd_done)
            rdata <= rx_byte;
    end

    a_no_wr_rd: assert property (@(posedge CLK) disable iff (RESET)
        !(wr && rd));

    a_ack_held_req: assert property (@(posedge CLK) disable iff (RESET)
        $rose(ack) |-> $past(wr || rd));

endmodule

`default_nettype wire

//--- i2c_engine/i2c_bit_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_macros.svh"

module i2c_bit_engine import eeprom_pkg::*; (
    input  logic     CLK,
    input  logic     RESET,
    input  logic     cmd_req,
    input  bit_cmd_t cmd,
    input  ee_byte_t cmd_tx_byte,
    input  logic     cmd_tx_nack,
    output logic     cmd_ack,
    output ee_byte_t rx_byte,
    output logic     rx_nack,
    output logic     scl,
    input  logic     sda_in,
    output logic     sda_oe
);

    localparam int unsigned HALF   = `EE_SCL_HALF;
    localparam int unsigned QTR    = HALF / 2;
    localparam int unsigned PERIOD = 2 * HALF;
    localparam int          PH_W   = $clog2(PERIOD);
    localparam int          BC_W   = $clog2(`EE_DATA_W + 1);
    localparam int unsigned LAST   = `EE_DATA_W;   // index of the ack slot

    eng_state_t      state;
    logic [PH_W-1:0] ph_cnt;
    logic [BC_W-1:0] bit_cnt;
    ee_byte_t        tx_sh;
    logic            bus_held;   // between START and STOP

    logic ph_fall;
    logic ph_set;
    logic ph_rise;
    logic ph_samp;
    logic ph_end;
    logic ack_slot;

    // points inside one bit period
    assign ph_fall  = (ph_cnt == '0);
    assign ph_set   = (ph_cnt == PH_W'(QTR));           // middle of SCL low
    assign ph_rise  = (ph_cnt == PH_W'(HALF));
    assign ph_samp  = (ph_cnt == PH_W'(HALF + QTR));    // middle of SCL high
    assign ph_end   = (ph_cnt == PH_W'(PERIOD - 1));
    assign ack_slot = (bit_cnt == BC_W'(LAST));

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state    <= ENG_IDLE;
            ph_cnt   <= '0;
            bit_cnt  <= '0;
            cmd_ack  <= 1'b0;
            rx_nack  <= 1'b0;
            scl      <= 1'b1;
            sda_oe   <= 1'b0;
            bus_held <= 1'b0;
        end else begin
            case (state)
                ENG_IDLE: begin
                    if (cmd_req) begin
                        ph_cnt  <= '0;
                        bit_cnt <= '0;
                        case (cmd)
                            CMD_START: state <= ENG_START;
                            CMD_STOP:  state <= ENG_STOP;
                            default:   state <= ENG_BYTE;
                        endcase
                    end
                end

                ENG_START, ENG_STOP, ENG_BYTE: begin
                    ph_cnt <= ph_end ? '0 : ph_cnt + PH_W'(1);

                    // from idle the START keeps SCL high throughout
                    if (ph_fall && bus_held) scl <= 1'b0;
                    if (ph_rise) scl <= 1'b1;

                    if (ph_set) begin
                        case (state)
                            ENG_START: sda_oe <= 1'b0;   // release for repeated START
                            ENG_STOP:  sda_oe <= 1'b1;
                            default: begin
                                if (ack_slot)
                                    sda_oe <= (cmd == CMD_READ) ? ~cmd_tx_nack : 1'b0;
                                else
                                    sda_oe <= (cmd == CMD_WRITE) ? ~tx_sh[`EE_DATA_W-1] : 1'b0;
                            end
                        endcase
                    end

                    if (ph_samp) begin
                        case (state)
                            ENG_START: begin
                                sda_oe   <= 1'b1;   // SDA falls with SCL high
                                bus_held <= 1'b1;
                            end
                            ENG_STOP: begin
                                sda_oe   <= 1'b0;   // SDA rises with SCL high
                                bus_held <= 1'b0;
                            end
                            default: begin
                                if (ack_slot)
                                    rx_nack <= sda_in;
                                else
                                    rx_byte <= {rx_byte[`EE_DATA_W-2:0], sda_in};
                            end
                        endcase
                    end

                    if (ph_end) begin
                        if (state != ENG_BYTE || ack_slot) begin
                            state   <= ENG_DONE;
                            cmd_ack <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + BC_W'(1);
                        end
                    end
                end

                ENG_DONE: begin
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        state   <= ENG_IDLE;
                    end
                end

                default: state <= ENG_IDLE;
            endcase
        end
    end

    // transmit shifter, MSB first
    always_ff @(posedge CLK) begin
        if (state == ENG_IDLE && cmd_req)
            tx_sh <= cmd_tx_byte;
        else if (state == ENG_BYTE && ph_end)
            tx_sh <= {tx_sh[`EE_DATA_W-2:0], 1'b0};
    end

    // cmd is read during the whole byte, not only at accept
    a_cmd_held: assert property (@(posedge CLK) disable iff (RESET)
        cmd_req && $past(cmd_req) |-> $stable(cmd) && $stable(cmd_tx_byte));

endmodule

`default_nettype wire

//--- common/eeprom_pkg.sv
`default_nettype none

`include "eeprom_macros.svh"

package eeprom_pkg;

    typedef logic [`EE_ADDR_W-1:0] ee_addr_t;
    typedef logic [`EE_DATA_W-1:0] ee_byte_t;

    // START while the bus is held gives a repeated START
    typedef enum logic [1:0] {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } bit_cmd_t;

    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_START,
        ENG_STOP,
        ENG_BYTE,   // 8 data bits plus ack slot
        ENG_DONE
    } eng_state_t;

    typedef enum logic [3:0] {
        IDLE,
        START_W,
        CTRL_W,
        ADDR_W,
        DATA_W,
        RESTART,
        CTRL_R,
        DATA_R,
        STOP,
        DONE
    } seq_state_t;

endpackage

`default_nettype wire

//--- common/eeprom_macros.svh
`ifndef EEPROM_MACROS_SVH
`define EEPROM_MACROS_SVH

// system clocks per SCL half period, 2 or more
`define EE_SCL_HALF 4

// host address, 2 K bytes
`define EE_ADDR_W 11

// data and bus byte
`define EE_DATA_W 8

// device type code, upper nibble of the control byte
`define EE_DEV_CODE 4'b1010

`endif
